// ==== sim.f ====
+incdir+include
logic/z80_bus_pkg.sv
logic/gpu_periph_pkg.sv
logic/z80_cycle_if.sv
logic/z80_bus_sampler.sv
logic/gpu_mem_port.sv
logic/io_port_regs.sv
logic/z80_read_driver.sv
logic/z80_bridge_top.sv
verif/tb_z80_bridge.sv

// ==== Bender.yml ====
package:
  name: z80_bridge

sources:
  - include_dirs:
      - include
    files:
      - logic/z80_bus_pkg.sv
      - logic/gpu_periph_pkg.sv
      - logic/z80_cycle_if.sv
      - logic/z80_bus_sampler.sv
      - logic/gpu_mem_port.sv
      - logic/io_port_regs.sv
      - logic/z80_read_driver.sv
      - logic/z80_bridge_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/tb_z80_bridge.sv

// ==== verif/tb_z80_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "z80_bridge_params.svh"

module tb_z80_bridge;
   import z80_bus_pkg::*;
   import gpu_periph_pkg::*;

   localparam int CLK_NS      = 8;
   localparam int HOLD_CYC    = 6 * 16;        // Six Z80 clocks per bus cycle
   localparam int IDLE_CYC    = 16;            // Gap between bus cycles
   localparam int FALL_LIMIT  = 20;            // RD release to rdata_ena low
   localparam int NUM_TESTS   = 6;
   localparam int MAX_BUS_CYC = 20;            // Most bus cycles in any one test
   localparam int WATCHDOG_NS = NUM_TESTS * MAX_BUS_CYC * 2 *
                                (HOLD_CYC + IDLE_CYC + FALL_LIMIT) * CLK_NS;
   localparam z80_addr_t WIN_BASE = {`MEMORY_RANGE, 19'd0};             // Window start
   localparam z80_addr_t ID_BASE  = {`MEMORY_RANGE, `BANK_ID_ADDR, 4'h0}; // Bank-ID block
   localparam z80_data_t ID_TABLE [16] = `BANK_ID_BYTES;

   logic      GPU_CLK, rst_n, z80_clk, m1_n, mreq_n, iorq_n, rd_n, wr_n;
   z80_addr_t z80_addr;
   z80_data_t z80_wdata, z80_rdata, gpu_rdata, gpu_wdata, ps2_dat, geo_wr_lo, geo_wr_hi;
   logic      rdata_ena, data_dir, oe_n, gpu_rd_rdy, gpu_wr_ena, gpu_rd_req;
   gpu_addr_t gpu_addr;
   logic      ps2_rdy, spkr_en, snd_data_tx, geo_wr_lo_strobe, geo_wr_hi_strobe;
   logic [2:0] ps2_status;
   snd_word_t snd_data;

   int        wr_cnt, rd_cnt, snd_cnt, spkr_cnt, lo_cnt, hi_cnt;   // Strobe pulse counts
   gpu_addr_t wr_addr, rd_addr;                                    // Address seen with strobe
   z80_data_t wr_data, lo_data, hi_data;
   snd_word_t snd_seen;
   logic [15:0] lfsr;                                              // RAM model random source
   z80_data_t ram_next;                                            // Byte the RAM returns next
   int        value_errors, other_errors;

   z80_bridge_top dut0 (.*);

   // ************************************************************************
   // Clocks, bus monitor and GPU RAM model
   // ************************************************************************
   initial begin
      GPU_CLK = 1'b0;
      forever #(CLK_NS / 2) GPU_CLK = ~GPU_CLK;
   end

   initial begin
      z80_clk = 1'b0;
      forever begin
         repeat (8) @(negedge GPU_CLK);   // Half a Z80 clock
         z80_clk = ~z80_clk;
      end
   end

   always @(negedge GPU_CLK) begin       // Outputs settled half a cycle after posedge
      if (gpu_wr_ena) begin
         wr_cnt++;
         wr_addr = gpu_addr;
         wr_data = gpu_wdata;
      end
      if (gpu_rd_req) begin
         rd_cnt++;
         rd_addr = gpu_addr;
      end
      if (snd_data_tx) begin
         snd_cnt++;
         snd_seen = snd_data;
      end
      if (spkr_en) spkr_cnt++;
      if (geo_wr_lo_strobe) begin
         lo_cnt++;
         lo_data = geo_wr_lo;
      end
      if (geo_wr_hi_strobe) begin
         hi_cnt++;
         hi_data = geo_wr_hi;
      end
   end

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11
   endfunction

   task automatic take_random_byte(output z80_data_t b);
      for (int i = 0; i < 8; i++) begin
         lfsr = lfsr_next(lfsr);          // One step per bit
         b    = {b[6:0], lfsr[0]};
      end
   endtask

   initial begin
      gpu_rdata  = '0;
      gpu_rd_rdy = 1'b0;
      lfsr       = 16'd13036;
      take_random_byte(ram_next);
      forever begin
         @(negedge GPU_CLK);
         if (gpu_rd_req) begin
            repeat (3) @(negedge GPU_CLK);   // RAM latency
            gpu_rdata  = ram_next;
            gpu_rd_rdy = 1'b1;
            @(negedge GPU_CLK);
            gpu_rd_rdy = 1'b0;
            take_random_byte(ram_next);
         end
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
      $display("TB FAILED");
      $finish;
   end

   // ************************************************************************
   // Compare tasks
   // ************************************************************************
   task automatic check_data(input string name, input z80_data_t got, input z80_data_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_gpu_addr(input string name, input gpu_addr_t got, input gpu_addr_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_snd(input string name, input snd_word_t got, input snd_word_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         value_errors++;
         $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         value_errors++;
         $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   // ************************************************************************
   // Bus model
   // ************************************************************************
   task automatic clear_counts();
      wr_cnt   = 0;
      rd_cnt   = 0;
      snd_cnt  = 0;
      spkr_cnt = 0;
      lo_cnt   = 0;
      hi_cnt   = 0;
   endtask

   task automatic drive_cycle(input logic is_io, input logic is_rd, input z80_addr_t a,
                              input z80_data_t d);
      @(negedge GPU_CLK);
      z80_addr  = a;
      z80_wdata = d;
      mreq_n    = is_io;                  // Exactly one of MREQ and IORQ low
      iorq_n    = ~is_io;
      rd_n      = ~is_rd;
      wr_n      = is_rd;
      repeat (HOLD_CYC) @(negedge GPU_CLK);
   endtask

   task automatic release_bus();
      int n;
      mreq_n = 1'b1;
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      wr_n   = 1'b1;
      n      = 0;
      while (rdata_ena !== 1'b0 && n < FALL_LIMIT) begin
         @(negedge GPU_CLK);
         n++;
      end
      if (rdata_ena !== 1'b0) begin
         other_errors++;
         $display("rdata_ena did not fall within %0d cycles of RD release", FALL_LIMIT);
      end
      repeat (IDLE_CYC) @(negedge GPU_CLK);
      check_bit("data_dir idle", data_dir, 1'b0);   // Back to input direction
      check_bit("oe_n idle", oe_n, 1'b1);
      check_data("z80_rdata idle", z80_rdata, 8'h00);
   endtask

   task automatic write_cycle(input logic is_io, input z80_addr_t a, input z80_data_t d);
      drive_cycle(is_io, 1'b0, a, d);
      release_bus();
   endtask

   task automatic read_check(input logic is_io, input z80_addr_t a, input z80_data_t exp,
                             input string name);
      drive_cycle(is_io, 1'b1, a, 8'h00);
      check_bit("rdata_ena", rdata_ena, 1'b1);   // Still driving while RD held
      check_bit("data_dir", data_dir, 1'b1);
      check_bit("oe_n", oe_n, 1'b0);
      check_data(name, z80_rdata, exp);
      release_bus();
   endtask

   // ************************************************************************
   // Directed tests
   // ************************************************************************
   task automatic reset_defaults();
      check_bit("gpu_wr_ena", gpu_wr_ena, 1'b0);
      check_bit("gpu_rd_req", gpu_rd_req, 1'b0);
      check_bit("spkr_en", spkr_en, 1'b0);
      check_bit("snd_data_tx", snd_data_tx, 1'b0);
      check_bit("geo_wr_lo_strobe", geo_wr_lo_strobe, 1'b0);
      check_bit("geo_wr_hi_strobe", geo_wr_hi_strobe, 1'b0);
      check_bit("rdata_ena", rdata_ena, 1'b0);
      check_bit("data_dir", data_dir, 1'b0);
      check_bit("oe_n", oe_n, 1'b1);
      read_check(1'b1, z80_addr_t'(`PORT_KBD_STAT), 8'h00, "PS/2 status after reset");
   endtask

   task automatic mem_write_decode();
      clear_counts();
      write_cycle(1'b0, WIN_BASE + 22'h00123, 8'hA5);
      check_count("gpu_wr_ena pulses", wr_cnt, 1);
      check_gpu_addr("gpu_addr, write", wr_addr, 20'h00123);
      check_data("gpu_wdata", wr_data, 8'hA5);
      clear_counts();
      write_cycle(1'b0, WIN_BASE + z80_addr_t'(`MEM_SIZE_BYTES - 1), 8'h3C);   // Last RAM byte
      check_count("gpu_wr_ena pulses, top", wr_cnt, 1);
      check_gpu_addr("gpu_addr, top", wr_addr, gpu_addr_t'(`MEM_SIZE_BYTES - 1));
      clear_counts();
      write_cycle(1'b0, WIN_BASE + z80_addr_t'(`MEM_SIZE_BYTES), 8'h5A);       // Past the RAM
      write_cycle(1'b0, 22'h000123, 8'h66);                                    // Outside window
      check_count("gpu_wr_ena pulses, unbacked", wr_cnt, 0);
   endtask

   task automatic mem_read_ram();
      z80_addr_t a;
      z80_data_t exp;
      for (int i = 0; i < 2; i++) begin
         a   = WIN_BASE + 22'h00456 + z80_addr_t'(i * 22'h111);
         exp = ram_next;                   // Byte the model answers with
         clear_counts();
         read_check(1'b0, a, exp, "z80_rdata, RAM read");
         check_count("gpu_rd_req pulses", rd_cnt, 1);
         check_gpu_addr("gpu_addr, read", rd_addr, gpu_addr_t'(a - WIN_BASE));
      end
   endtask

   task automatic window_read_back();
      clear_counts();
      read_check(1'b0, WIN_BASE + 22'h20000, 8'hFF, "z80_rdata, above RAM");
      for (int i = 0; i < 16; i++) begin
         read_check(1'b0, ID_BASE + z80_addr_t'(i), ID_TABLE[i], "z80_rdata, bank ID");
      end
      check_count("gpu_rd_req pulses, unbacked", rd_cnt, 0);
   endtask

   task automatic port_write_strobes();
      clear_counts();
      write_cycle(1'b1, z80_addr_t'(`PORT_SND_TONE), 8'h5A);
      check_count("snd_data_tx pulses, tone", snd_cnt, 1);
      check_snd("snd_data, tone", snd_seen, {1'b1, 8'h5A});   // Tone selects bit 8
      clear_counts();
      write_cycle(1'b1, z80_addr_t'(`PORT_SND_DUR), 8'h33);
      check_count("snd_data_tx pulses, duration", snd_cnt, 1);
      check_snd("snd_data, duration", snd_seen, {1'b0, 8'h33});
      clear_counts();
      write_cycle(1'b1, z80_addr_t'(`PORT_SPKR), 8'h01);
      check_count("spkr_en pulses", spkr_cnt, 1);
      check_count("snd_data_tx pulses, speaker", snd_cnt, 0);
      clear_counts();
      write_cycle(1'b1, z80_addr_t'(`PORT_GEO_LO), 8'hC3);
      check_count("geo_wr_lo_strobe pulses", lo_cnt, 1);
      check_count("geo_wr_hi_strobe pulses, low write", hi_cnt, 0);
      check_data("geo_wr_lo", lo_data, 8'hC3);
      clear_counts();
      write_cycle(1'b1, z80_addr_t'(`PORT_GEO_HI), 8'h7E);
      check_count("geo_wr_hi_strobe pulses", hi_cnt, 1);
      check_count("geo_wr_lo_strobe pulses, high write", lo_cnt, 0);
      check_data("geo_wr_hi", hi_data, 8'h7E);
      check_count("gpu_wr_ena pulses, port writes", wr_cnt, 0);
   endtask

   task automatic keyboard_latch();
      ps2_stat_t exp_stat;
      z80_data_t key;
      key = 8'hB5;                         // Bit 7 set, a break code
      @(negedge GPU_CLK);
      ps2_dat    = key;
      ps2_status = 3'b110;                 // Uneven so bit order shows
      ps2_rdy    = 1'b1;
      repeat (6) @(negedge GPU_CLK);
      ps2_rdy = 1'b0;
      repeat (4) @(negedge GPU_CLK);
      exp_stat      = '0;
      exp_stat[0]   = 1'b1;                // Data ready
      exp_stat[1]   = key[7];
      exp_stat[4:2] = ps2_status;
      read_check(1'b1, z80_addr_t'(`PORT_KBD_STAT), exp_stat, "z80_rdata, PS/2 status");
      read_check(1'b1, z80_addr_t'(`PORT_KBD_DATA), key, "z80_rdata, PS/2 data");
      exp_stat[0] = 1'b0;                  // Consumed by the data read
      read_check(1'b1, z80_addr_t'(`PORT_KBD_STAT), exp_stat, "z80_rdata, status again");
      read_check(1'b1, z80_addr_t'(`PORT_KBD_DATA), 8'h00, "z80_rdata, data again");
   endtask

   initial begin
      value_errors = 0;
      other_errors = 0;
      rst_n        = 1'b0;
      m1_n         = 1'b1;
      mreq_n       = 1'b1;
      iorq_n       = 1'b1;
      rd_n         = 1'b1;
      wr_n         = 1'b1;
      z80_addr     = '0;
      z80_wdata    = '0;
      ps2_rdy      = 1'b0;
      ps2_dat      = '0;
      ps2_status   = '0;
      clear_counts();
      repeat (5) @(negedge GPU_CLK);
      rst_n = 1'b1;
      reset_defaults();
      mem_write_decode();
      mem_read_ram();
      window_read_back();
      port_write_strobes();
      keyboard_latch();
      $display("Check summary: %0d value errors, %0d other errors", value_errors,
               other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== logic/z80_bridge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module z80_bridge_top (
   input  wire logic                    GPU_CLK,
   input  wire logic                    rst_n,
   // Z80 bus
   input  wire logic                    z80_clk,
   input  wire logic                    m1_n,
   input  wire logic                    mreq_n,
   input  wire logic                    iorq_n,
   input  wire logic                    rd_n,
   input  wire logic                    wr_n,
   input  wire z80_bus_pkg::z80_addr_t  z80_addr,
   input  wire z80_bus_pkg::z80_data_t  z80_wdata,
   output z80_bus_pkg::z80_data_t       z80_rdata,
   output logic                         rdata_ena,
   output logic                         data_dir,
   output logic                         oe_n,
   // GPU RAM
   input  wire z80_bus_pkg::z80_data_t  gpu_rdata,
   input  wire logic                    gpu_rd_rdy,
   output logic                         gpu_wr_ena,
   output logic                         gpu_rd_req,
   output gpu_periph_pkg::gpu_addr_t    gpu_addr,
   output z80_bus_pkg::z80_data_t       gpu_wdata,
   // Keyboard, sound and geometry unit
   input  wire logic                    ps2_rdy,
   input  wire z80_bus_pkg::z80_data_t  ps2_dat,
   input  wire logic [2:0]              ps2_status,
   output logic                         spkr_en,
   output logic                         snd_data_tx,
   output gpu_periph_pkg::snd_word_t    snd_data,
   output logic                         geo_wr_lo_strobe,
   output logic                         geo_wr_hi_strobe,
   output z80_bus_pkg::z80_data_t       geo_wr_lo,
   output z80_bus_pkg::z80_data_t       geo_wr_hi
);
   import z80_bus_pkg::*;

   logic      mem_rsp_valid;
   z80_data_t mem_rsp_data;
   logic      port_rsp_valid;
   z80_data_t port_rsp_data;

   z80_cycle_if cyc ();

   z80_bus_sampler u_sampler (
      .GPU_CLK, .rst_n, .z80_clk, .m1_n, .mreq_n, .iorq_n, .rd_n, .wr_n,
      .z80_addr, .z80_wdata, .cyc(cyc)
   );

   gpu_mem_port u_mem (
      .GPU_CLK, .rst_n, .cyc(cyc), .gpu_rdata, .gpu_rd_rdy, .gpu_wr_ena, .gpu_rd_req,
      .gpu_addr, .gpu_wdata, .mem_rsp_valid, .mem_rsp_data
   );

   io_port_regs u_io (
      .GPU_CLK, .rst_n, .cyc(cyc), .ps2_rdy, .ps2_dat, .ps2_status, .spkr_en,
      .snd_data_tx, .snd_data, .geo_wr_lo_strobe, .geo_wr_hi_strobe, .geo_wr_lo,
      .geo_wr_hi, .port_rsp_valid, .port_rsp_data
   );

   z80_read_driver u_rd (
      .GPU_CLK, .rst_n, .rd_strobe(cyc.rd_strobe), .mem_rsp_valid, .mem_rsp_data,
      .port_rsp_valid, .port_rsp_data, .z80_rdata, .rdata_ena, .data_dir, .oe_n
   );

endmodule

`default_nettype wire

// ==== logic/z80_read_driver.sv ====
`timescale 1ns/1ps
`default_nettype none

module z80_read_driver (
   input  wire logic                    GPU_CLK,
   input  wire logic                    rst_n,
   input  wire logic                    rd_strobe,
   input  wire logic                    mem_rsp_valid,
   input  wire z80_bus_pkg::z80_data_t  mem_rsp_data,
   input  wire logic                    port_rsp_valid,
   input  wire z80_bus_pkg::z80_data_t  port_rsp_data,
   output z80_bus_pkg::z80_data_t       z80_rdata,
   output logic                         rdata_ena,
   output logic                         data_dir,
   output logic                         oe_n
);
   import z80_bus_pkg::*;

   localparam logic DIR_IN  = 1'b0;   // Translator toward FPGA
   localparam logic DIR_OUT = 1'b1;   // Translator toward Z80

   z80_data_t rdata_i;
   z80_data_t rdata_s1;
   logic      ena_i;
   logic      ena_s1;
   logic      dir_i;
   logic      dir_s1;
   logic      oe_n_i;
   logic      oe_n_s1;

   always_ff @(posedge GPU_CLK or negedge rst_n) begin
      if (!rst_n) begin
         ena_i     <= 1'b0;
         dir_i     <= DIR_IN;
         oe_n_i    <= 1'b1;
         ena_s1    <= 1'b0;
         dir_s1    <= DIR_IN;
         oe_n_s1   <= 1'b1;
         rdata_ena <= 1'b0;
         data_dir  <= DIR_IN;
         oe_n      <= 1'b1;
      end else begin
         if (rd_strobe) begin                            // RD released
            ena_i  <= 1'b0;
            dir_i  <= DIR_IN;
            oe_n_i <= 1'b1;
         end else if (mem_rsp_valid || port_rsp_valid) begin
            ena_i  <= 1'b1;
            dir_i  <= DIR_OUT;
            oe_n_i <= 1'b0;
         end
         ena_s1    <= ena_i;                             // Two stages to the bus
         dir_s1    <= dir_i;
         oe_n_s1   <= oe_n_i;
         rdata_ena <= ena_s1;
         data_dir  <= dir_s1;
         oe_n      <= oe_n_s1;
      end
   end

   always_ff @(posedge GPU_CLK) begin
      if (rd_strobe)           rdata_i <= '0;
      else if (mem_rsp_valid)  rdata_i <= mem_rsp_data;
      else if (port_rsp_valid) rdata_i <= port_rsp_data;
      rdata_s1  <= rdata_i;
      z80_rdata <= rdata_s1;
   end

endmodule

`default_nettype wire

// ==== logic/io_port_regs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "z80_bridge_params.svh"

module io_port_regs (
   input  wire logic                    GPU_CLK,
   input  wire logic                    rst_n,
   z80_cycle_if.io                      cyc,
   input  wire logic                    ps2_rdy,
   input  wire z80_bus_pkg::z80_data_t  ps2_dat,
   input  wire logic [2:0]              ps2_status,
   output logic                         spkr_en,
   output logic                         snd_data_tx,
   output gpu_periph_pkg::snd_word_t    snd_data,
   output logic                         geo_wr_lo_strobe,
   output logic                         geo_wr_hi_strobe,
   output z80_bus_pkg::z80_data_t       geo_wr_lo,
   output z80_bus_pkg::z80_data_t       geo_wr_hi,
   output logic                         port_rsp_valid,
   output z80_bus_pkg::z80_data_t       port_rsp_data
);
   import z80_bus_pkg::*;
   import gpu_periph_pkg::*;

   z80_data_t port;              // Low address byte selects the port
   logic      wr_tone;
   logic      wr_dur;
   logic      rd_in_range;
   z80_data_t ps2_hist;          // Ready history, newest in bit 0
   z80_data_t ps2_char;          // Latched key character
   ps2_stat_t ps2_stat;          // Latched keyboard status

   assign port        = cyc.addr[7:0];
   assign wr_tone     = cyc.port_wr_start && (port == `PORT_SND_TONE);
   assign wr_dur      = cyc.port_wr_start && (port == `PORT_SND_DUR);
   assign rd_in_range = (port >= `PORT_RD_FIRST) && (port <= `PORT_RD_LAST);

   // ************************************************************************
   // Port write strobes
   // ************************************************************************
   always_ff @(posedge GPU_CLK or negedge rst_n) begin
      if (!rst_n) begin
         spkr_en          <= 1'b0;
         snd_data_tx      <= 1'b0;
         geo_wr_lo_strobe <= 1'b0;
         geo_wr_hi_strobe <= 1'b0;
      end else begin
         spkr_en          <= cyc.port_wr_start && (port == `PORT_SPKR);
         snd_data_tx      <= wr_tone || wr_dur;
         geo_wr_lo_strobe <= cyc.port_wr_start && (port == `PORT_GEO_LO);
         geo_wr_hi_strobe <= cyc.port_wr_start && (port == `PORT_GEO_HI);
      end
   end

   always_ff @(posedge GPU_CLK) begin
      if (wr_tone || wr_dur) snd_data <= {wr_tone, cyc.wdata};   // Bit 8 selects tone
      if (cyc.port_wr_start && (port == `PORT_GEO_LO)) geo_wr_lo <= cyc.wdata;
      if (cyc.port_wr_start && (port == `PORT_GEO_HI)) geo_wr_hi <= cyc.wdata;
   end

   // ************************************************************************
   // Keyboard latch and port reads
   // ************************************************************************
   always_ff @(posedge GPU_CLK or negedge rst_n) begin
      if (!rst_n) begin
         ps2_hist       <= '0;
         ps2_char       <= '0;
         ps2_stat       <= '0;
         port_rsp_valid <= 1'b0;
         port_rsp_data  <= '0;
      end else begin
         ps2_hist       <= {ps2_hist[6:0], ps2_rdy};
         port_rsp_valid <= cyc.port_rd_active && rd_in_range;
         if (cyc.port_rd_start) begin
            case (port)
               `PORT_KBD_DATA: begin
                  port_rsp_data <= ps2_char;
                  ps2_char      <= '0;        // Character consumed
                  ps2_stat[0]   <= 1'b0;      // No longer ready
               end
               `PORT_KBD_STAT: port_rsp_data <= ps2_stat;
               default:        port_rsp_data <= '0;
            endcase
         end
         if (ps2_hist == `PS2_RDY_PATTERN) begin   // New key wins over a read
            ps2_char <= ps2_dat;
            ps2_stat <= {3'b000, ps2_status, ps2_dat[7], 1'b1};
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/gpu_mem_port.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "z80_bridge_params.svh"

module gpu_mem_port (
   input  wire logic                    GPU_CLK,
   input  wire logic                    rst_n,
   z80_cycle_if.mem                     cyc,
   input  wire z80_bus_pkg::z80_data_t  gpu_rdata,
   input  wire logic                    gpu_rd_rdy,
   output logic                         gpu_wr_ena,
   output logic                         gpu_rd_req,
   output gpu_periph_pkg::gpu_addr_t    gpu_addr,
   output z80_bus_pkg::z80_data_t       gpu_wdata,
   output logic                         mem_rsp_valid,
   output z80_bus_pkg::z80_data_t       mem_rsp_data
);
   import z80_bus_pkg::*;

   localparam z80_data_t BANK_ID [16] = `BANK_ID_BYTES;

   logic in_bank;               // Inside the 512 KB window
   logic in_range;              // Backed by GPU RAM
   logic in_id;                 // Bank-ID block at top of window

   assign in_bank  = cyc.addr[21:19] == `MEMORY_RANGE;
   assign in_range = in_bank && (cyc.addr[18:0] < `MEM_SIZE_BYTES);
   assign in_id    = in_bank && (cyc.addr[18:4] == `BANK_ID_ADDR);

   // ************************************************************************
   // GPU RAM requests
   // ************************************************************************
   always_ff @(posedge GPU_CLK or negedge rst_n) begin
      if (!rst_n) begin
         gpu_wr_ena <= 1'b0;
         gpu_rd_req <= 1'b0;
      end else begin
         gpu_wr_ena <= cyc.mem_wr_start && in_range;   // One clock per write
         gpu_rd_req <= cyc.mem_rd_start && in_range;   // One clock per read
      end
   end

   always_ff @(posedge GPU_CLK) begin
      if ((cyc.mem_wr_start || cyc.mem_rd_start) && in_range) begin
         gpu_addr <= {1'b0, cyc.addr[18:0]};   // Offset inside window
      end
      if (cyc.mem_wr_start && in_range) begin
         gpu_wdata <= cyc.wdata;
      end
   end

   // ************************************************************************
   // Read response
   // ************************************************************************
   assign mem_rsp_valid = cyc.mem_rd_active &&
                          ((in_range && gpu_rd_rdy) || (in_bank && !in_range));

   always_comb begin
      if (in_range)   mem_rsp_data = gpu_rdata;                 // RAM byte
      else if (in_id) mem_rsp_data = BANK_ID[cyc.addr[3:0]];    // Bank-ID table
      else            mem_rsp_data = 8'hff;                     // Unbacked window
   end

endmodule

`default_nettype wire

// ==== logic/z80_bus_sampler.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "z80_bridge_params.svh"

module z80_bus_sampler (
   input  wire logic                   GPU_CLK,
   input  wire logic                   rst_n,
   input  wire logic                   z80_clk,
   input  wire logic                   m1_n,
   input  wire logic                   mreq_n,
   input  wire logic                   iorq_n,
   input  wire logic                   rd_n,
   input  wire logic                   wr_n,
   input  wire z80_bus_pkg::z80_addr_t z80_addr,
   input  wire z80_bus_pkg::z80_data_t z80_wdata,
   z80_cycle_if.sampler                cyc
);
   import z80_bus_pkg::*;

   // Kind index 0 mem write, 1 mem read, 2 port write, 3 port read
   localparam filt_cnt_t FILT_LEN [4] = '{`Z80_CLK_FILTER, `Z80_CLK_FILTER,
                                          `Z80_CLK_FILTER_P, `Z80_CLK_FILTER_P};

   logic       clk_r;           // Z80_CLK first stage
   logic       clk_r2;          // Z80_CLK second stage
   logic       m1_r;
   logic       mreq_r;
   logic       iorq_r;
   logic       rd_r;
   logic       wr_r;
   z80_addr_t  addr_r;
   z80_data_t  wdata_r;
   logic       zclk;            // Either Z80_CLK edge
   logic [3:0] op;              // Raw decoded kinds
   logic [3:0] idle;            // Strobe of each kind released
   logic [3:0] level;           // Qualified cycle levels
   logic [3:0] level_d;         // Delayed levels for one-shots
   filt_cnt_t  cnt [4];         // Hysteresis counters

   assign zclk = clk_r ^ clk_r2;

   // M1 high and exactly one of MREQ and IORQ
   assign op[0] = m1_r & ~mreq_r &  iorq_r &  rd_r & ~wr_r;
   assign op[1] = m1_r & ~mreq_r &  iorq_r & ~rd_r &  wr_r;
   assign op[2] = m1_r &  mreq_r & ~iorq_r &  rd_r & ~wr_r;
   assign op[3] = m1_r &  mreq_r & ~iorq_r & ~rd_r &  wr_r;
   assign idle  = {rd_r, wr_r, rd_r, wr_r};

   // ************************************************************************
   // Input registers
   // ************************************************************************
   always_ff @(posedge GPU_CLK or negedge rst_n) begin
      if (!rst_n) begin
         clk_r  <= 1'b0;
         clk_r2 <= 1'b0;
         m1_r   <= 1'b1;         // Controls idle high
         mreq_r <= 1'b1;
         iorq_r <= 1'b1;
         rd_r   <= 1'b1;
         wr_r   <= 1'b1;
      end else begin
         clk_r  <= z80_clk;
         clk_r2 <= clk_r;
         m1_r   <= m1_n;
         mreq_r <= mreq_n;
         iorq_r <= iorq_n;
         rd_r   <= rd_n;
         wr_r   <= wr_n;
      end
   end

   always_ff @(posedge GPU_CLK) begin
      addr_r  <= z80_addr;
      wdata_r <= z80_wdata;
   end

   // ************************************************************************
   // Stability filter
   // ************************************************************************
   always_ff @(posedge GPU_CLK or negedge rst_n) begin
      if (!rst_n) begin
         level   <= '0;
         level_d <= '0;
         for (int k = 0; k < 4; k++) cnt[k] <= '0;
      end else begin
         level_d <= level;
         for (int k = 0; k < 4; k++) begin
            if (idle[k]) begin
               cnt[k]   <= '0;   // Cleared while strobe inactive
               level[k] <= 1'b0;
            end else if (zclk && op[k]) begin
               if (cnt[k] != FILT_LEN[k]) cnt[k] <= cnt[k] + 1'b1;
               else level[k] <= 1'b1;   // Seen on filter+1 edges
            end
         end
      end
   end

   assign cyc.addr           = addr_r;
   assign cyc.wdata          = wdata_r;
   assign cyc.mem_wr_start   = level[0] & ~level_d[0];
   assign cyc.mem_rd_start   = level[1] & ~level_d[1];
   assign cyc.port_wr_start  = level[2] & ~level_d[2];
   assign cyc.port_rd_start  = level[3] & ~level_d[3];
   assign cyc.mem_rd_active  = level[1];
   assign cyc.port_rd_active = level[3];
   assign cyc.rd_strobe      = rd_r;

endmodule

`default_nettype wire

// ==== logic/z80_cycle_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface z80_cycle_if;
   import z80_bus_pkg::*;

   z80_addr_t addr;            // Registered host address
   z80_data_t wdata;           // Registered write data
   logic      mem_wr_start;    // One-shot, qualified memory write
   logic      mem_rd_start;    // One-shot, qualified memory read
   logic      port_wr_start;   // One-shot, qualified port write
   logic      port_rd_start;   // One-shot, qualified port read
   logic      mem_rd_active;   // Held while memory read lasts
   logic      port_rd_active;  // Held while port read lasts
   logic      rd_strobe;       // Registered RD, active low

   modport sampler (output addr, wdata, mem_wr_start, mem_rd_start, port_wr_start,
                    port_rd_start, mem_rd_active, port_rd_active, rd_strobe);
   modport mem     (input addr, wdata, mem_wr_start, mem_rd_start, mem_rd_active);
   modport io      (input addr, wdata, port_wr_start, port_rd_start, port_rd_active);

endinterface

`default_nettype wire

// ==== logic/gpu_periph_pkg.sv ====
`default_nettype none

// ***************************************************************************
// GPU side peripheral types
// ***************************************************************************
package gpu_periph_pkg;

   typedef logic [19:0] gpu_addr_t;   // GPU RAM byte address
   typedef logic [8:0]  snd_word_t;   // Bit 8 high for tone, low for duration
   typedef logic [7:0]  ps2_stat_t;   // Ready, break, 3 keyboard bits, 3 zeros

endpackage

`default_nettype wire

// ==== logic/z80_bus_pkg.sv ====
`default_nettype none

// ***************************************************************************
// Z80 host side types
// ***************************************************************************
package z80_bus_pkg;

   typedef logic [21:0] z80_addr_t;   // Host 22-bit extended address
   typedef logic [7:0]  z80_data_t;   // One bus data byte
   typedef logic [2:0]  filt_cnt_t;   // Stability filter edge count

endpackage

`default_nettype wire

// ==== include/z80_bridge_params.svh ====
`ifndef Z80_BRIDGE_PARAMS_SVH
`define Z80_BRIDGE_PARAMS_SVH

// ***************************************************************************
// Bus cycle filter
// ***************************************************************************
`define Z80_CLK_FILTER   z80_bus_pkg::filt_cnt_t'(0)   // Extra edges, memory cycles
`define Z80_CLK_FILTER_P z80_bus_pkg::filt_cnt_t'(2)   // Extra edges, port cycles

// ***************************************************************************
// Memory window
// ***************************************************************************
`define MEMORY_RANGE     3'b010           // Address bits 21:19 of the 512 KB window
`define MEM_SIZE_BYTES   19'd40960        // GPU RAM size, above reads 0xFF
`define BANK_ID_ADDR     {15{1'b1}}       // Bits 18:4 of the ID block
`define BANK_ID_BYTES    '{8'd9, 8'd3, 8'd71, 8'd80, 8'd85, 8'd32, 8'd69, 8'd80, \
                           8'd52, 8'd67, 8'd69, 8'd49, 8'd48, 8'd0, 8'd255, 8'd255}

// ***************************************************************************
// IO ports
// ***************************************************************************
`define PORT_KBD_DATA    8'd240           // Keyboard character
`define PORT_KBD_STAT    8'd241           // Keyboard status
`define PORT_SPKR        8'd242           // Speaker enable pulse
`define PORT_SND_TONE    8'd244           // Sound tone register
`define PORT_SND_DUR     8'd245           // Sound duration register
`define PORT_GEO_LO      8'd246           // Geometry unit low byte
`define PORT_GEO_HI      8'd247           // Geometry unit high byte
`define PORT_RD_FIRST    8'd240           // Decoded read range
`define PORT_RD_LAST     8'd243

`define PS2_RDY_PATTERN  8'b00001111      // Ready held 4 cycles after low

`endif
